// File: src/mipsPkg.sv
package mipsPkg;

    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 5;

    typedef logic [dataWidth-1:0]    wordT;
    typedef logic [regAddrWidth-1:0] regAddrT;

    localparam wordT resetPc    = 32'hbfc0_0000; // boot vector
    localparam wordT instrBytes = 32'd4;

    // primary opcodes, instr[31:26]
    typedef enum logic [5:0] {
        opSpecial = 6'h00, // R-type, decoded by funct
        opAddiu   = 6'h09,
        opSlti    = 6'h0a,
        opSltiu   = 6'h0b,
        opAndi    = 6'h0c,
        opOri     = 6'h0d,
        opXori    = 6'h0e,
        opLui     = 6'h0f
    } opcodeT;

    // function field of special, instr[5:0]
    typedef enum logic [5:0] {
        fnSll   = 6'h00,
        fnSrl   = 6'h02,
        fnSra   = 6'h03,
        fnMfhi  = 6'h10,
        fnMflo  = 6'h12,
        fnMult  = 6'h18,
        fnMultu = 6'h19,
        fnAddu  = 6'h21,
        fnSubu  = 6'h23,
        fnAnd   = 6'h24,
        fnOr    = 6'h25,
        fnXor   = 6'h26,
        fnNor   = 6'h27,
        fnSlt   = 6'h2a,
        fnSltu  = 6'h2b
    } functT;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluNor,
        aluSlt,
        aluSltu,
        aluSll,
        aluSrl,
        aluSra,
        aluLui
    } aluOpT;

    typedef enum logic [1:0] {
        mdNone,
        mdMult,
        mdMultu
    } mdOpT;

    // what the execute stage hands to writeback
    typedef enum logic [1:0] {
        resSrcAlu,
        resSrcHi,
        resSrcLo
    } resultSrcT;

endpackage

// File: src/aluUnit.sv
`timescale 1ns/100ps
module aluUnit (
    input  mipsPkg::aluOpT aluOp,
    input  mipsPkg::wordT  srcA,
    input  mipsPkg::wordT  srcB,
    output mipsPkg::wordT  aluResult
);
    import mipsPkg::*;

    logic [4:0] shamt;
    logic       lessSigned;
    logic       lessUnsigned;

    assign shamt        = srcA[4:0];
    assign lessSigned   = $signed(srcA) < $signed(srcB);
    assign lessUnsigned = srcA < srcB;

    always_comb begin
        case (aluOp)
            aluAdd:  aluResult = srcA + srcB; // no overflow trap
            aluSub:  aluResult = srcA - srcB;
            aluAnd:  aluResult = srcA & srcB;
            aluOr:   aluResult = srcA | srcB;
            aluXor:  aluResult = srcA ^ srcB;
            aluNor:  aluResult = ~(srcA | srcB);
            aluSlt:  aluResult = {{(dataWidth-1){1'b0}}, lessSigned};
            aluSltu: aluResult = {{(dataWidth-1){1'b0}}, lessUnsigned};
            aluSll:  aluResult = srcB << shamt;
            aluSrl:  aluResult = srcB >> shamt;
            aluSra:  aluResult = $signed(srcB) >>> shamt;
            aluLui:  aluResult = {srcB[15:0], 16'h0000}; // imm to upper half
            default: aluResult = '0;
        endcase
    end

endmodule

// File: src/mulDivUnit.sv
`timescale 1ns/100ps
module mulDivUnit (
    input  logic          clk,
    input  logic          rst,
    input  mipsPkg::mdOpT mdOp,
    input  mipsPkg::wordT srcA,
    input  mipsPkg::wordT srcB,
    output mipsPkg::wordT hi,
    output mipsPkg::wordT lo
);
    import mipsPkg::*;

    logic signed [2*dataWidth-1:0] signedProd;
    logic        [2*dataWidth-1:0] unsignedProd;

    // both operands sign extended to 64 bits by the signed context
    assign signedProd   = $signed(srcA) * $signed(srcB);
    assign unsignedProd = {{dataWidth{1'b0}}, srcA} * {{dataWidth{1'b0}}, srcB};

    // visible to an mfhi/mflo in the very next cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            hi <= '0;
            lo <= '0;
        end else if (mdOp != mdNone) begin
            if (mdOp == mdMult)
                {hi, lo} <= signedProd;
            else
                {hi, lo} <= unsignedProd;
        end
    end

endmodule

// File: src/writeBack.sv
`timescale 1ns/100ps
module writeBack (
    input  logic               clk,
    input  logic               rst,
    input  mipsPkg::resultSrcT resultSrc,
    input  logic               regWrite,
    input  mipsPkg::regAddrT   regAddr,
    input  mipsPkg::wordT      pc,
    input  mipsPkg::wordT      aluResult,
    input  mipsPkg::wordT      hi,
    input  mipsPkg::wordT      lo,
    output mipsPkg::wordT      exResult,
    output mipsPkg::wordT      wbPc,
    output logic               wbRegWrite,
    output mipsPkg::regAddrT   wbRegAddr,
    output mipsPkg::wordT      wbData
);
    import mipsPkg::*;

    // also feeds the distance-one forward path
    always_comb begin
        case (resultSrc)
            resSrcHi: exResult = hi;
            resSrcLo: exResult = lo;
            default:  exResult = aluResult;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wbRegWrite <= 1'b0;
        end else begin
            wbRegWrite <= regWrite;
        end
    end

    always_ff @(posedge clk) begin
        wbPc      <= pc;
        wbRegAddr <= regAddr;
        wbData    <= exResult;
    end

endmodule

// File: src/frontEnd.sv
`timescale 1ns/100ps
module frontEnd (
    input  logic               clk,
    input  logic               rst,
    input  mipsPkg::wordT      instr,
    input  mipsPkg::wordT      exResult,
    input  logic               wbRegWrite,
    input  mipsPkg::regAddrT   wbRegAddr,
    input  mipsPkg::wordT      wbData,
    output logic               instrEn,
    output mipsPkg::wordT      instrAddr,
    output mipsPkg::wordT      srcA,
    output mipsPkg::wordT      srcB,
    output mipsPkg::aluOpT     exAluOp,
    output mipsPkg::mdOpT      exMdOp,
    output mipsPkg::resultSrcT exResultSrc,
    output logic               exRegWrite,
    output mipsPkg::regAddrT   exRegAddr,
    output mipsPkg::wordT      exPc
);
    import mipsPkg::*;

    wordT      decPc;         // pc of the word in decode
    logic      decValid;
    wordT      regFile [1:31]; // r0 is not stored
    opcodeT    opcode;
    functT     funct;
    regAddrT   rs;
    regAddrT   rt;
    regAddrT   rd;
    regAddrT   destAddr;
    logic      known;
    logic      isImm;
    logic      zeroExt;
    logic      useSa;
    logic      decWrite;
    wordT      immExt;
    wordT      opA;
    wordT      opB;
    aluOpT     decAluOp;
    mdOpT      decMdOp;
    resultSrcT decResultSrc;

    function automatic wordT forwardOperand(regAddrT addr, logic exWr, regAddrT exAddr,
                                            wordT exVal, logic wbWr, regAddrT wbAddr,
                                            wordT wbVal, wordT rfVal);
        if (exWr && exAddr == addr)
            return exVal; // newest result wins
        if (wbWr && wbAddr == addr)
            return wbVal;
        return rfVal;
    endfunction

    assign instrEn   = !rst;
    assign instrAddr = decValid ? decPc + instrBytes : resetPc;

    always_ff @(posedge clk) begin
        if (rst) begin
            decValid <= 1'b0;
        end else begin
            decValid <= 1'b1; // a fetch went out this cycle
        end
    end

    always_ff @(posedge clk) begin
        decPc <= instrAddr;
    end

    assign opcode = opcodeT'(instr[31:26]);
    assign funct  = functT'(instr[5:0]);
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];

    always_comb begin
        decAluOp     = aluAdd;
        decMdOp      = mdNone;
        decResultSrc = resSrcAlu;
        known        = 1'b1;
        if (opcode == opSpecial) begin
            case (funct)
                fnSll:   decAluOp = aluSll;
                fnSrl:   decAluOp = aluSrl;
                fnSra:   decAluOp = aluSra;
                fnMfhi:  decResultSrc = resSrcHi;
                fnMflo:  decResultSrc = resSrcLo;
                fnMult:  decMdOp = mdMult;
                fnMultu: decMdOp = mdMultu;
                fnAddu:  decAluOp = aluAdd;
                fnSubu:  decAluOp = aluSub;
                fnAnd:   decAluOp = aluAnd;
                fnOr:    decAluOp = aluOr;
                fnXor:   decAluOp = aluXor;
                fnNor:   decAluOp = aluNor;
                fnSlt:   decAluOp = aluSlt;
                fnSltu:  decAluOp = aluSltu;
                default: known = 1'b0; // becomes a bubble
            endcase
        end else begin
            case (opcode)
                opAddiu: decAluOp = aluAdd;
                opSlti:  decAluOp = aluSlt;
                opSltiu: decAluOp = aluSltu;
                opAndi:  decAluOp = aluAnd;
                opOri:   decAluOp = aluOr;
                opXori:  decAluOp = aluXor;
                opLui:   decAluOp = aluLui;
                default: known = 1'b0;
            endcase
        end
    end

    assign isImm    = opcode != opSpecial;
    assign zeroExt  = opcode inside {opAndi, opOri, opXori, opLui};
    assign immExt   = zeroExt ? {16'h0000, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};
    assign destAddr = isImm ? rt : rd;
    assign useSa    = !isImm && decAluOp inside {aluSll, aluSrl, aluSra}; // constant shifts
    // mult writes only hi/lo
    assign decWrite = decValid && known && decMdOp == mdNone && destAddr != '0;

    always_comb begin
        opA = forwardOperand(rs, exRegWrite, exRegAddr, exResult, wbRegWrite, wbRegAddr,
                             wbData, (rs == '0) ? '0 : regFile[rs]);
        opB = forwardOperand(rt, exRegWrite, exRegAddr, exResult, wbRegWrite, wbRegAddr,
                             wbData, (rt == '0) ? '0 : regFile[rt]);
    end

    always_ff @(posedge clk) begin
        if (wbRegWrite && wbRegAddr != '0)
            regFile[wbRegAddr] <= wbData;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            exRegWrite <= 1'b0;
            exMdOp     <= mdNone;
        end else begin
            exRegWrite <= decWrite;
            exMdOp     <= decValid ? decMdOp : mdNone;
        end
    end

    always_ff @(posedge clk) begin
        exAluOp     <= decAluOp;
        exResultSrc <= decResultSrc;
        exRegAddr   <= destAddr;
        exPc        <= decPc;
        srcA        <= useSa ? {{(dataWidth-5){1'b0}}, instr[10:6]} : opA;
        srcB        <= isImm ? immExt : opB;
    end

endmodule

// File: src/cpuTop.sv
`timescale 1ns/100ps
module cpuTop (
    input  logic             clk,
    input  logic             rst,
    input  mipsPkg::wordT    inst_sram_rdata,
    output logic             inst_sram_en,
    output mipsPkg::wordT    inst_sram_addr,
    output mipsPkg::wordT    debug_wb_pc,
    output logic             debug_wb_rf_wen,
    output mipsPkg::regAddrT debug_wb_rf_wnum,
    output mipsPkg::wordT    debug_wb_rf_wdata
);
    import mipsPkg::*;

    wordT      srcA;
    wordT      srcB;
    aluOpT     exAluOp;
    mdOpT      exMdOp;
    resultSrcT exResultSrc;
    logic      exRegWrite;
    regAddrT   exRegAddr;
    wordT      exPc;
    wordT      exResult;
    wordT      aluResult;
    wordT      hi;
    wordT      lo;

    frontEnd frontEnd (
        .clk         (clk              ), // input
        .rst         (rst              ), // input
        .instr       (inst_sram_rdata  ), // input  [31:0]
        .exResult    (exResult         ), // input  [31:0]
        .wbRegWrite  (debug_wb_rf_wen  ), // regfile write shares the debug port
        .wbRegAddr   (debug_wb_rf_wnum ), // input  [ 4:0]
        .wbData      (debug_wb_rf_wdata), // input  [31:0]
        .instrEn     (inst_sram_en     ), // output
        .instrAddr   (inst_sram_addr   ), // output [31:0]
        .srcA        (srcA             ), // output [31:0]
        .srcB        (srcB             ), // output [31:0]
        .exAluOp     (exAluOp          ), // output [ 3:0]
        .exMdOp      (exMdOp           ), // output [ 1:0]
        .exResultSrc (exResultSrc      ), // output [ 1:0]
        .exRegWrite  (exRegWrite       ), // output
        .exRegAddr   (exRegAddr        ), // output [ 4:0]
        .exPc        (exPc             )  // output [31:0]
    );

    aluUnit aluUnit (
        .aluOp     (exAluOp  ),
        .srcA      (srcA     ),
        .srcB      (srcB     ),
        .aluResult (aluResult)
    );

    mulDivUnit mulDivUnit (
        .clk  (clk   ),
        .rst  (rst   ),
        .mdOp (exMdOp),
        .srcA (srcA  ),
        .srcB (srcB  ),
        .hi   (hi    ),
        .lo   (lo    )
    );

    writeBack writeBack (
        .clk        (clk              ), // input
        .rst        (rst              ), // input
        .resultSrc  (exResultSrc      ), // input  [ 1:0]
        .regWrite   (exRegWrite       ), // input
        .regAddr    (exRegAddr        ), // input  [ 4:0]
        .pc         (exPc             ), // input  [31:0]
        .aluResult  (aluResult        ), // input  [31:0]
        .hi         (hi               ), // input  [31:0]
        .lo         (lo               ), // input  [31:0]
        .exResult   (exResult         ), // output [31:0]
        .wbPc       (debug_wb_pc      ), // output [31:0]
        .wbRegWrite (debug_wb_rf_wen  ), // output
        .wbRegAddr  (debug_wb_rf_wnum ), // output [ 4:0]
        .wbData     (debug_wb_rf_wdata)  // output [31:0]
    );

endmodule

// File: verif/cpuTb.sv
`timescale 1ns/100ps
module cpuTb;
    import mipsPkg::*;

    localparam int bodyLen       = 240; // random instructions after register setup
    localparam int timeoutCycles = 2000;

    logic    clk;
    logic    rst;
    wordT    inst_sram_rdata;
    logic    inst_sram_en;
    wordT    inst_sram_addr;
    wordT    debug_wb_pc;
    logic    debug_wb_rf_wen;
    regAddrT debug_wb_rf_wnum;
    wordT    debug_wb_rf_wdata;

    integer  seed = 32'h3c85_aa47;
    wordT    prog [$];
    wordT    refRegs [32];
    wordT    refHi;
    wordT    refLo;
    wordT    expPc [$];
    regAddrT expNum [$];
    wordT    expData [$];
    wordT    expFetch;
    regAddrT lastDest [2];
    int      errors   = 0;
    int      checked  = 0;
    int      expTotal = 0;

    functT       threeRegFns [8] = '{fnAddu, fnSubu, fnAnd, fnOr, fnXor, fnNor, fnSlt, fnSltu};
    functT       shiftFns [3]    = '{fnSll, fnSrl, fnSra};
    opcodeT      immOps [7]      = '{opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui};
    logic [5:0]  badOps [5]      = '{6'h02, 6'h04, 6'h08, 6'h23, 6'h2b}; // j, beq, addi, lw, sw
    logic [5:0]  badFns [4]      = '{6'h1a, 6'h11, 6'h13, 6'h04}; // div, mthi, mtlo, sllv

    cpuTop UUT (
        .clk               (clk              ),
        .rst               (rst              ),
        .inst_sram_rdata   (inst_sram_rdata  ),
        .inst_sram_en      (inst_sram_en     ),
        .inst_sram_addr    (inst_sram_addr   ),
        .debug_wb_pc       (debug_wb_pc      ),
        .debug_wb_rf_wen   (debug_wb_rf_wen  ),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum ),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    always #2 clk = ~clk;

    function automatic wordT fetchWord(wordT addr);
        wordT idx;
        idx = (addr - resetPc) >> 2;
        if (idx < prog.size())
            return prog[idx];
        return 32'h0000_0000; // sll r0 past the end writes nothing
    endfunction

    // instruction sram with one cycle read latency
    always @(posedge clk) begin
        if (inst_sram_en)
            inst_sram_rdata <= fetchWord(inst_sram_addr);
    end

    function automatic int randBelow(int n);
        return {$random(seed)} % n;
    endfunction

    function automatic wordT rType(regAddrT rs, regAddrT rt, regAddrT rd, logic [4:0] sa,
                                   logic [5:0] fn);
        return {6'h00, rs, rt, rd, sa, fn};
    endfunction

    function automatic wordT iType(logic [5:0] op, regAddrT rs, regAddrT rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic regAddrT pickSrc();
        if (randBelow(12) == 0)
            return 5'd0; // r0 must read as zero
        if (randBelow(10) < 7)
            return lastDest[randBelow(2)]; // mostly a recent result
        return regAddrT'(randBelow(32));
    endfunction

    function automatic regAddrT pickDest();
        if (randBelow(16) == 0)
            return 5'd0;
        return regAddrT'(1 + randBelow(31));
    endfunction

    task automatic addWord(wordT w, regAddrT dest);
        prog.push_back(w);
        if (dest != 5'd0) begin
            lastDest[1] = lastDest[0];
            lastDest[0] = dest;
        end
    endtask

    task automatic buildProgram();
        int      kind;
        regAddrT rs;
        regAddrT rt;
        regAddrT rd;
        wordT    w;
        // give every register a known value first
        for (int r = 1; r < 32; r++) begin
            addWord(iType(opLui, 5'd0, regAddrT'(r), 16'(randBelow(65536))), regAddrT'(r));
            addWord(iType(opOri, regAddrT'(r), regAddrT'(r), 16'(randBelow(65536))),
                    regAddrT'(r));
        end
        for (int i = 0; i < bodyLen; i++) begin
            kind = randBelow(24);
            rs   = pickSrc();
            rt   = pickSrc();
            rd   = pickDest();
            if (kind < 8) begin
                addWord(rType(rs, rt, rd, 5'd0, threeRegFns[randBelow(8)]), rd);
            end else if (kind < 11) begin
                w = rType(5'd0, rt, rd, 5'(randBelow(32)), shiftFns[randBelow(3)]);
                addWord(w, rd);
            end else if (kind < 19) begin
                addWord(iType(immOps[randBelow(7)], rs, rd, 16'(randBelow(65536))), rd);
            end else if (kind < 20) begin
                w = rType(rs, rt, 5'd0, 5'd0, randBelow(2) ? fnMultu : fnMult);
                addWord(w, 5'd0);
                addWord(rType(5'd0, 5'd0, rd, 5'd0, fnMfhi), rd); // right behind the mult
                rd = pickDest();
                addWord(rType(5'd0, 5'd0, rd, 5'd0, fnMflo), rd);
            end else if (kind < 21) begin
                addWord(rType(5'd0, 5'd0, rd, 5'd0, randBelow(2) ? fnMfhi : fnMflo), rd);
            end else if (kind < 22) begin
                w        = $random(seed);
                w[31:26] = badOps[randBelow(5)];
                addWord(w, 5'd0);
            end else if (kind < 23) begin
                w        = $random(seed);
                w[31:26] = 6'h00;
                w[5:0]   = badFns[randBelow(4)];
                addWord(w, 5'd0);
            end else begin
                addWord(rType(rs, rt, 5'd0, 5'd0, fnAddu), 5'd0); // dropped write to r0
            end
        end
    endtask

    // architectural model of one instruction
    function automatic logic refExec(wordT instr, output regAddrT dest, output wordT value);
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [4:0]  sa;
        wordT        a;
        wordT        b;
        wordT        sImm;
        wordT        zImm;
        longint      pa;
        longint      pb;
        logic [63:0] prod;
        logic        wr;
        op    = instr[31:26];
        fn    = instr[5:0];
        sa    = instr[10:6];
        a     = refRegs[instr[25:21]];
        b     = refRegs[instr[20:16]];
        sImm  = {{16{instr[15]}}, instr[15:0]};
        zImm  = {16'h0000, instr[15:0]};
        wr    = 1'b1;
        value = '0;
        dest  = instr[15:11];
        if (op == 6'h00) begin
            case (fn)
                fnSll:   value = b << sa;
                fnSrl:   value = b >> sa;
                fnSra:   value = $signed(b) >>> sa;
                fnMfhi:  value = refHi;
                fnMflo:  value = refLo;
                fnAddu:  value = a + b;
                fnSubu:  value = a - b;
                fnAnd:   value = a & b;
                fnOr:    value = a | b;
                fnXor:   value = a ^ b;
                fnNor:   value = ~(a | b);
                fnSlt:   value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                fnSltu:  value = (a < b) ? 32'd1 : 32'd0;
                fnMult: begin
                    pa            = $signed(a);
                    pb            = $signed(b);
                    prod          = pa * pb;
                    {refHi, refLo} = prod;
                    wr            = 1'b0;
                end
                fnMultu: begin
                    prod           = {32'h0, a} * {32'h0, b};
                    {refHi, refLo} = prod;
                    wr             = 1'b0;
                end
                default: wr = 1'b0;
            endcase
        end else begin
            dest = instr[20:16];
            case (op)
                opAddiu: value = a + sImm;
                opSlti:  value = ($signed(a) < $signed(sImm)) ? 32'd1 : 32'd0;
                opSltiu: value = (a < sImm) ? 32'd1 : 32'd0;
                opAndi:  value = a & zImm;
                opOri:   value = a | zImm;
                opXori:  value = a ^ zImm;
                opLui:   value = {instr[15:0], 16'h0000};
                default: wr = 1'b0;
            endcase
        end
        if (dest == 5'd0)
            wr = 1'b0;
        if (wr)
            refRegs[dest] = value;
        return wr;
    endfunction

    task automatic predictWrites();
        regAddrT d;
        wordT    v;
        for (int i = 0; i < prog.size(); i++) begin
            if (refExec(prog[i], d, v)) begin
                expPc.push_back(resetPc + 4 * i);
                expNum.push_back(d);
                expData.push_back(v);
            end
        end
        expTotal = expPc.size();
    endtask

    task automatic checkValue(string name, wordT got, wordT exp);
        if (got !== exp) begin
            $display("** Error: %s is %h, expected %h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    // fetch starts at the boot vector and steps one word per cycle
    always @(negedge clk) begin
        if (rst) begin
            checkValue("inst_sram_en", inst_sram_en, 32'd0);
        end else begin
            checkValue("inst_sram_en", inst_sram_en, 32'd1);
            checkValue("inst_sram_addr", inst_sram_addr, expFetch);
            expFetch = expFetch + 32'd4;
        end
    end

    // debug port monitor sampled away from the active edge
    always @(negedge clk) begin
        if (rst) begin
            if (debug_wb_rf_wen !== 1'b0) begin
                $display("register write reported while reset is active at %0t", $time);
                errors++;
            end
        end else if (debug_wb_rf_wen === 1'b1) begin
            if (expPc.size() == 0) begin
                $display("unexpected extra register write at %0t", $time);
                errors++;
            end else begin
                checkValue("debug_wb_pc", debug_wb_pc, expPc.pop_front());
                checkValue("debug_wb_rf_wnum", debug_wb_rf_wnum, expNum.pop_front());
                checkValue("debug_wb_rf_wdata", debug_wb_rf_wdata, expData.pop_front());
                checked++;
            end
        end else if (debug_wb_rf_wen !== 1'b0) begin
            $display("write enable is unknown at %0t", $time);
            errors++;
        end
    end

    initial begin
        int cycles;
        clk             = 1'b0;
        rst             = 1'b1;
        inst_sram_rdata = '0;
        refHi           = '0;
        refLo           = '0;
        expFetch        = resetPc;
        lastDest[0]     = 5'd0;
        lastDest[1]     = 5'd0;
        foreach (refRegs[i])
            refRegs[i] = '0;
        buildProgram();
        predictWrites();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        cycles = 0;
        while (checked < expTotal && cycles < timeoutCycles) begin
            @(posedge clk);
            cycles++;
        end
        if (checked < expTotal) begin
            $display("timed out with %0d of %0d register writes seen", checked, expTotal);
            errors++;
        end
        repeat (8) @(posedge clk); // catch stray writes after the program
        $display("%0d errors, %0d of %0d writes checked", errors, checked, expTotal);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// File: tb.f
src/mipsPkg.sv
src/aluUnit.sv
src/mulDivUnit.sv
src/writeBack.sv
src/frontEnd.sv
src/cpuTop.sv
verif/cpuTb.sv

// File: Bender.yml
package:
  name: mips_pipeline

sources:
  - src/mipsPkg.sv
  - src/aluUnit.sv
  - src/mulDivUnit.sv
  - src/writeBack.sv
  - src/frontEnd.sv
  - src/cpuTop.sv
  - target: test
    files:
      - verif/cpuTb.sv
